// File: mem_subsys_top.f
design/brisc_pkg.sv
design/axil_req_slave.sv
design/line_cache.sv
design/line_memory.sv
design/axil_resp_side.sv
design/mem_subsys_top.sv
sim/mem_subsys_assert.sv
sim/mem_subsys_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the memory subsystem testbench with Verilator.
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  -f mem_subsys_top.f --top-module mem_subsys_tb -Mdir obj_dir -o sim_mem_subsys
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/sim_mem_subsys > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qx "TEST PASS" sim.log; then
  exit 0
fi
echo "Pass message not found in sim.log"
exit 1

// File: sim/mem_subsys_tb.sv
`timescale 1ns/1ps
`default_nettype none

module mem_subsys_tb
  import brisc_pkg::*;
();

  localparam int CYCLE_LIMIT = 8000;  // ~150 ops of at most 30 cycles, plus margin.
  localparam int WAIT_LIMIT  = 100;

  logic        clk, rst_n, awvalid, awready, wvalid, wready, bvalid, bready;
  logic        arvalid, arready, rvalid, rready;
  logic [31:0] awaddr, wdata, araddr, rdata, rd;
  logic [3:0]  wstrb;
  logic [1:0]  bresp, rresp;
  logic [31:0] model [256];
  logic [31:0] rng;
  int          errors, tests_failed, base, cycles;

  mem_subsys_top uut (.*);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= CYCLE_LIMIT) begin
      $display("Run stopped after %0d cycles without finishing", cycles);
      $display("TEST FAIL");
      $finish;
    end
  end

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    s ^= s << 13;
    s ^= s >> 17;
    s ^= s << 5;
    return s;
  endfunction

  task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp) begin
      $display("CHECK FAILED at %0t: %s expected %h, got %h", $time, name, exp, act);
      errors++;
    end
  endtask

  task automatic fail(input string what);
    $display("ERROR at %0t: %s", $time, what);
    errors++;
  endtask

  task automatic finish_test(input string name);
    if (errors != base) tests_failed++;
    $display("%-14s %s", name, (errors == base) ? "ok" : "failed");
    base = errors;
  endtask

  // Byte merge into the reference model.
  task automatic model_write(input logic [31:0] a, input logic [31:0] d, input logic [3:0] s);
    for (int b = 0; b < 4; b++) begin
      if (s[b]) model[a[9:2]][b*8 +: 8] = d[b*8 +: 8];
    end
  endtask

  task automatic axil_write(input logic [31:0] a, input logic [31:0] d, input logic [3:0] s);
    int n;
    awaddr = a;
    wdata = d;
    wstrb = s;
    awvalid = 1'b1;
    wvalid = 1'b1;
    n = 0;
    do begin
      @(posedge clk);
      n++;
    end while (!(awready && wready) && n < WAIT_LIMIT);
    if (n >= WAIT_LIMIT) fail("write address and data never accepted");
    @(negedge clk);
    awvalid = 1'b0;
    wvalid = 1'b0;
    n = 0;
    while (!bvalid && n < WAIT_LIMIT) begin
      @(negedge clk);
      n++;
    end
    if (n >= WAIT_LIMIT) fail("no write response");
    check("bresp", 32'd0, 32'(bresp));  // OKAY.
    @(negedge clk);
    model_write(a, d, s);
  endtask

  task automatic axil_read(input logic [31:0] a, output logic [31:0] d);
    int n;
    araddr = a;
    arvalid = 1'b1;
    n = 0;
    do begin
      @(posedge clk);
      n++;
    end while (!arready && n < WAIT_LIMIT);
    if (n >= WAIT_LIMIT) fail("read address never accepted");
    @(negedge clk);
    arvalid = 1'b0;
    n = 0;
    while (!rvalid && n < WAIT_LIMIT) begin
      @(negedge clk);
      n++;
    end
    if (n >= WAIT_LIMIT) fail("no read response");
    check("rresp", 32'd0, 32'(rresp));  // OKAY.
    d = rdata;
    @(negedge clk);
  endtask

  task automatic read_check(input logic [31:0] a);
    logic [31:0] d;
    axil_read(a, d);
    check("rdata", model[a[9:2]], d);
  endtask

  task automatic write_read_back();
    axil_write(32'h0000_0104, 32'hCAFE_0001, 4'hF);
    read_check(32'h0000_0104);
    axil_write(32'h1000_0208, 32'h1234_5678, 4'hF);
    read_check(32'h0000_0208);  // High bits alias away.
    finish_test("write_read");
  endtask

  task automatic strobe_merge();
    axil_write(32'h0C4, 32'h1122_3344, 4'hF);
    axil_write(32'h0C4, 32'hAABB_CCDD, 4'b0101);
    axil_write(32'h0C4, 32'h5566_7788, 4'b1000);
    read_check(32'h0C4);
    finish_test("byte_strobes");
  endtask

  task automatic dirty_evict();
    logic [31:0] d;
    for (int t = 0; t < 4; t++) begin
      rng = xorshift(rng);
      axil_write({22'd0, t[3:0], 2'd1, 2'd2, 2'd0}, rng, 4'hF);
    end
    for (int t = 0; t < 4; t++) read_check({22'd0, t[3:0], 2'd1, 2'd2, 2'd0});
    axil_read({22'd0, 4'd9, 2'd1, 2'd2, 2'd0}, d);
    check("rdata", 32'd0, d);
    finish_test("dirty_evict");
  endtask

  task automatic stall_responses();
    logic [31:0] held;
    bready = 1'b0;
    rready = 1'b0;
    awaddr = 32'h2A0;
    wdata = 32'h0BAD_F00D;
    wstrb = 4'hF;
    awvalid = 1'b1;
    wvalid = 1'b1;
    for (int n = 0; n < WAIT_LIMIT && !(awready && wready); n++) @(negedge clk);
    @(negedge clk);
    awvalid = 1'b0;
    wvalid = 1'b0;
    model_write(32'h2A0, 32'h0BAD_F00D, 4'hF);
    for (int n = 0; n < WAIT_LIMIT && !bvalid; n++) @(negedge clk);
    if (!bvalid) fail("no write response before the stall");
    araddr = 32'h2A0;
    arvalid = 1'b1;
    for (int i = 0; i < 20; i++) begin
      @(posedge clk);
      if (arready) fail("read accepted while write response stalled");
      check("bvalid", 32'd1, 32'(bvalid));
      @(negedge clk);
    end
    bready = 1'b1;
    for (int n = 0; n < WAIT_LIMIT && !arready; n++) @(negedge clk);
    if (!arready) fail("read address never accepted after the stall");
    @(negedge clk);
    arvalid = 1'b0;
    for (int n = 0; n < WAIT_LIMIT && !rvalid; n++) @(negedge clk);
    if (!rvalid) fail("no read response before the stall");
    held = rdata;
    for (int i = 0; i < 20; i++) begin
      @(negedge clk);
      check("rvalid", 32'd1, 32'(rvalid));
      check("rdata", held, rdata);
    end
    rready = 1'b1;
    @(negedge clk);
    check("rdata", model[8'hA8], held);
    finish_test("back_pressure");
  endtask

  task automatic write_before_read();
    logic got_b;
    logic got_r;
    logic aw_acc;
    logic ar_acc;
    int   n;
    got_b = 1'b0;
    got_r = 1'b0;
    n = 0;
    awaddr = 32'h3F0;
    wdata = 32'h7E57_0005;
    wstrb = 4'hF;
    araddr = 32'h3F0;
    awvalid = 1'b1;
    wvalid = 1'b1;
    arvalid = 1'b1;
    model_write(32'h3F0, 32'h7E57_0005, 4'hF);
    while (!got_r && n < 2 * WAIT_LIMIT) begin
      @(posedge clk);
      aw_acc = awvalid && awready;
      ar_acc = arvalid && arready;
      if (rvalid && !got_b) fail("read response came before write response");
      if (bvalid) got_b = 1'b1;
      if (rvalid) begin
        got_r = 1'b1;
        rd = rdata;
      end
      @(negedge clk);
      if (aw_acc) begin
        awvalid = 1'b0;
        wvalid = 1'b0;
      end
      if (ar_acc) arvalid = 1'b0;
      n++;
    end
    if (!got_r) fail("write and read pair did not complete");
    check("rdata", model[8'hFC], rd);
    finish_test("write_priority");
  endtask

  task automatic random_ops();
    logic [31:0] a;
    for (int i = 0; i < 120; i++) begin
      rng = xorshift(rng);
      a = {22'd0, rng[9:2], 2'b00};
      if (rng[31]) begin
        rng = xorshift(rng);
        axil_write(a, rng, rng[7:4]);
      end else begin
        read_check(a);
      end
    end
    finish_test("random");
  endtask

  initial begin
    rst_n = 1'b0;
    {awvalid, wvalid, arvalid} = 3'b000;
    {bready, rready} = 2'b11;
    {awaddr, wdata, araddr, wstrb} = '0;
    rng = 32'd1614;
    for (int i = 0; i < 256; i++) model[i] = 32'd0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    write_read_back();
    strobe_merge();
    dirty_evict();
    stall_responses();
    write_before_read();
    random_ops();
    $display("Summary: 6 tests, %0d failed, %0d errors", tests_failed, errors);
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: sim/mem_subsys_assert.sv
`timescale 1ns/1ps
`default_nettype none

module mem_subsys_assert
  import brisc_pkg::*;
(
  input wire logic                  clk,
  input wire logic                  rst_n,
  input wire logic                  bvalid,
  input wire logic                  bready,
  input wire logic [1:0]            bresp,
  input wire logic                  rvalid,
  input wire logic                  rready,
  input wire logic [WORD_WIDTH-1:0] rdata,
  input wire logic [1:0]            rresp,
  input wire logic                  req_write,
  input wire logic                  fill,
  input wire logic                  mem_req,
  input wire logic                  mem_store
);

  a_b_hold: assert property (@(posedge clk) disable iff (!rst_n)
    bvalid && !bready |=> bvalid && $stable(bresp))
    else $error("B channel dropped or changed before bready");

  a_r_hold: assert property (@(posedge clk) disable iff (!rst_n)
    rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp))
    else $error("R channel dropped or changed before rready");

  // One channel at a time, and the one that matches the request.
  a_one_resp: assert property (@(posedge clk) disable iff (!rst_n)
    (bvalid || rvalid) |-> (bvalid != rvalid) && (bvalid == req_write))
    else $error("Response on both channels or on the wrong one");

  // A fill is always the answer to a load issued one delay earlier.
  a_fill_origin: assert property (@(posedge clk) disable iff (!rst_n)
    fill |-> $past(mem_req && !mem_store, MEM_RESP_DELAY))
    else $error("Fill without a matching load");

endmodule

bind mem_subsys_top mem_subsys_assert u_assert (.*);

`default_nettype wire

// File: design/mem_subsys_top.sv
`timescale 1ns/1ps
`default_nettype none

module mem_subsys_top
  import brisc_pkg::*;
(
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic [AXI_ADDR_WIDTH-1:0] awaddr,
  input  logic                      awvalid,
  output logic                      awready,
  input  logic [WORD_WIDTH-1:0]     wdata,
  input  logic [STRB_WIDTH-1:0]     wstrb,
  input  logic                      wvalid,
  output logic                      wready,
  output logic [1:0]                bresp,
  output logic                      bvalid,
  input  logic                      bready,
  input  logic [AXI_ADDR_WIDTH-1:0] araddr,
  input  logic                      arvalid,
  output logic                      arready,
  output logic [WORD_WIDTH-1:0]     rdata,
  output logic [1:0]                rresp,
  output logic                      rvalid,
  input  logic                      rready
);

  logic                        req_valid;
  logic                        req_ready;
  logic                        req_write;
  addr_u                       req_addr;
  logic [WORD_WIDTH-1:0]       req_wdata;
  logic [STRB_WIDTH-1:0]       req_wstrb;
  logic                        resp_valid;
  logic                        resp_ready;
  logic                        resp_write;
  logic [WORD_WIDTH-1:0]       resp_rdata;
  logic                        resp_done;
  logic                        mem_req;
  logic                        mem_store;
  logic [LINE_ADDR_WIDTH-1:0]  mem_line;
  logic [CACHE_LINE_WIDTH-1:0] mem_evict_data;
  logic                        fill;
  logic [LINE_ADDR_WIDTH-1:0]  fill_line;
  logic [CACHE_LINE_WIDTH-1:0] fill_data;

  axil_req_slave u_req (
    .clk, .rst_n, .awaddr, .awvalid, .awready, .wdata, .wstrb, .wvalid, .wready,
    .araddr, .arvalid, .arready, .req_valid, .req_write, .req_addr, .req_wdata,
    .req_wstrb, .req_ready, .resp_done
  );

  line_cache u_cache (
    .clk, .rst_n, .req_valid, .req_write, .req_addr, .req_wdata, .req_wstrb,
    .req_ready, .resp_valid, .resp_write, .resp_rdata, .resp_ready, .mem_req,
    .mem_store, .mem_line, .mem_evict_data, .fill, .fill_line, .fill_data
  );

  line_memory u_mem (
    .clk, .rst_n, .mem_req, .mem_store, .mem_line, .mem_evict_data, .fill,
    .fill_line, .fill_data
  );

  axil_resp_side u_resp (
    .clk, .rst_n, .resp_valid, .resp_write, .resp_rdata, .resp_ready, .bvalid,
    .bresp, .bready, .rvalid, .rdata, .rresp, .rready, .resp_done
  );

endmodule

`default_nettype wire

// File: design/axil_resp_side.sv
`timescale 1ns/1ps
`default_nettype none

module axil_resp_side
  import brisc_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  resp_valid,
  input  logic                  resp_write,
  input  logic [WORD_WIDTH-1:0] resp_rdata,
  output logic                  resp_ready,
  output logic                  bvalid,
  output logic [1:0]            bresp,
  input  logic                  bready,
  output logic                  rvalid,
  output logic [WORD_WIDTH-1:0] rdata,
  output logic [1:0]            rresp,
  input  logic                  rready,
  output logic                  resp_done
);

  logic full;      // Holding register occupied.
  logic is_write;

  assign resp_ready = ~full;
  assign bvalid     = full & is_write;
  assign rvalid     = full & ~is_write;
  assign bresp      = RESP_OKAY;
  assign rresp      = RESP_OKAY;
  assign resp_done  = (bvalid & bready) | (rvalid & rready);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      full <= 1'b0;
    end else if (resp_valid && resp_ready) begin
      full <= 1'b1;
    end else if (resp_done) begin
      full <= 1'b0;
    end
  end

  // Held until the master takes it.
  always_ff @(posedge clk) begin
    if (resp_valid && resp_ready) begin
      is_write <= resp_write;
      rdata    <= resp_rdata;
    end
  end

endmodule

`default_nettype wire

// File: design/line_memory.sv
`timescale 1ns/1ps
`default_nettype none

module line_memory
  import brisc_pkg::*;
(
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        mem_req,
  input  logic                        mem_store,
  input  logic [LINE_ADDR_WIDTH-1:0]  mem_line,
  input  logic [CACHE_LINE_WIDTH-1:0] mem_evict_data,
  output logic                        fill,
  output logic [LINE_ADDR_WIDTH-1:0]  fill_line,
  output logic [CACHE_LINE_WIDTH-1:0] fill_data
);

  logic [CACHE_LINE_WIDTH-1:0] lines     [MEM_LINES];
  logic [MEM_RESP_DELAY-1:0]   pipe_req;
  logic [MEM_RESP_DELAY-1:0]   pipe_store;
  logic [LINE_ADDR_WIDTH-1:0]  pipe_line [MEM_RESP_DELAY];
  logic [CACHE_LINE_WIDTH-1:0] pipe_data [MEM_RESP_DELAY];

  logic                        out_req;
  logic                        out_store;
  logic [LINE_ADDR_WIDTH-1:0]  out_line;
  logic [CACHE_LINE_WIDTH-1:0] out_data;

  assign out_req   = pipe_req[MEM_RESP_DELAY-1];
  assign out_store = pipe_store[MEM_RESP_DELAY-1];
  assign out_line  = pipe_line[MEM_RESP_DELAY-1];
  assign out_data  = pipe_data[MEM_RESP_DELAY-1];

  //////////////////////////////
  // Delay pipeline, strictly in order.
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pipe_req <= '0;
    end else begin
      pipe_req[0] <= mem_req;
      for (int i = 1; i < MEM_RESP_DELAY; i++) begin
        pipe_req[i] <= pipe_req[i-1];
      end
    end
  end

  always_ff @(posedge clk) begin
    pipe_store[0] <= mem_store;
    pipe_line[0]  <= mem_line;
    pipe_data[0]  <= mem_evict_data;
    for (int i = 1; i < MEM_RESP_DELAY; i++) begin
      pipe_store[i] <= pipe_store[i-1];
      pipe_line[i]  <= pipe_line[i-1];
      pipe_data[i]  <= pipe_data[i-1];
    end
  end

  //////////////////////////////
  // Line array.
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < MEM_LINES; i++) begin
        lines[i] <= '0;
      end
    end else if (out_req && out_store) begin
      lines[out_line] <= out_data;
    end
  end

  // Read at delivery so earlier stores are visible.
  assign fill      = out_req & ~out_store;
  assign fill_line = out_line;
  assign fill_data = lines[out_line];

endmodule

`default_nettype wire

// File: design/line_cache.sv
`timescale 1ns/1ps
`default_nettype none

module line_cache
  import brisc_pkg::*;
(
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        req_valid,
  input  logic                        req_write,
  input  addr_u                       req_addr,
  input  logic [WORD_WIDTH-1:0]       req_wdata,
  input  logic [STRB_WIDTH-1:0]       req_wstrb,
  output logic                        req_ready,
  output logic                        resp_valid,
  output logic                        resp_write,
  output logic [WORD_WIDTH-1:0]       resp_rdata,
  input  logic                        resp_ready,
  output logic                        mem_req,
  output logic                        mem_store,
  output logic [LINE_ADDR_WIDTH-1:0]  mem_line,
  output logic [CACHE_LINE_WIDTH-1:0] mem_evict_data,
  input  logic                        fill,
  input  logic [LINE_ADDR_WIDTH-1:0]  fill_line,
  input  logic [CACHE_LINE_WIDTH-1:0] fill_data
);

  logic [2:0]                  state;
  logic [DELAY_CNT_WIDTH-1:0]  wait_cnt;
  logic [CACHE_SETS-1:0]       valid;
  logic [CACHE_SETS-1:0]       dirty;
  logic [TAG_WIDTH-1:0]        tags  [CACHE_SETS];
  logic [CACHE_LINE_WIDTH-1:0] lines [CACHE_SETS];

  logic                        cur_write;
  addr_u                       cur_addr;
  logic [WORD_WIDTH-1:0]       cur_wdata;
  logic [STRB_WIDTH-1:0]       cur_wstrb;

  logic [INDEX_WIDTH-1:0]      set_idx;
  logic [TAG_WIDTH-1:0]        cur_tag;
  logic                        hit;
  logic                        evict;
  logic                        fill_match;
  logic [WORD_WIDTH-1:0]       old_word;
  logic [WORD_WIDTH-1:0]       new_word;

  assign set_idx    = cur_addr.fields.index;
  assign cur_tag    = cur_addr.fields.tag;
  assign hit        = valid[set_idx] && (tags[set_idx] == cur_tag);
  assign evict      = valid[set_idx] && dirty[set_idx] && !hit;
  assign fill_match = fill && (fill_line == {cur_tag, set_idx});
  assign old_word   = lines[set_idx][cur_addr.fields.word*WORD_WIDTH +: WORD_WIDTH];

  // Byte merge for writes.
  always_comb begin
    new_word = old_word;
    for (int b = 0; b < STRB_WIDTH; b++) begin
      if (cur_wstrb[b]) begin
        new_word[b*BYTE_WIDTH +: BYTE_WIDTH] = cur_wdata[b*BYTE_WIDTH +: BYTE_WIDTH];
      end
    end
  end

  assign req_ready      = (state == ST_IDLE);
  assign resp_valid     = (state == ST_RESPOND);
  assign resp_write     = cur_write;
  assign mem_req        = (state == ST_LOOKUP) && !hit;
  assign mem_store      = mem_req && evict;  // Victim goes out first.
  assign mem_line       = mem_store ? {tags[set_idx], set_idx} : {cur_tag, set_idx};
  assign mem_evict_data = lines[set_idx];

  //////////////////////////////
  // Control state.
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state    <= ST_IDLE;
      wait_cnt <= '0;
      valid    <= '0;
      dirty    <= '0;
    end else begin
      case (state)
        ST_IDLE: begin
          if (req_valid) begin
            state <= ST_LOOKUP;
          end
        end
        ST_LOOKUP: begin
          if (hit) begin
            if (cur_write) begin
              dirty[set_idx] <= 1'b1;
            end
            state <= ST_RESPOND;
          end else if (evict) begin
            dirty[set_idx] <= 1'b0;  // Line is clean once stored.
            wait_cnt       <= DELAY_CNT_WIDTH'(MEM_RESP_DELAY - 1);
            state          <= ST_EVICT;
          end else begin
            state <= ST_FILL_WAIT;
          end
        end
        ST_EVICT: begin
          // Let the victim land before the refill goes out.
          if (wait_cnt == '0) begin
            state <= ST_LOOKUP;
          end else begin
            wait_cnt <= wait_cnt - 1'b1;
          end
        end
        ST_FILL_WAIT: begin
          if (fill_match) begin
            valid[set_idx] <= 1'b1;
            dirty[set_idx] <= 1'b0;
            state          <= ST_LOOKUP;  // Replays as a hit.
          end
        end
        ST_RESPOND: begin
          if (resp_ready) begin
            state <= ST_IDLE;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  //////////////////////////////
  // Request, tag and line storage.
  always_ff @(posedge clk) begin
    if (state == ST_IDLE && req_valid) begin
      cur_write <= req_write;
      cur_addr  <= req_addr;
      cur_wdata <= req_wdata;
      cur_wstrb <= req_wstrb;
    end
    if (state == ST_LOOKUP && hit) begin
      resp_rdata <= old_word;
      if (cur_write) begin
        lines[set_idx][cur_addr.fields.word*WORD_WIDTH +: WORD_WIDTH] <= new_word;
      end
    end
    if (state == ST_FILL_WAIT && fill_match) begin
      lines[set_idx] <= fill_data;
      tags[set_idx]  <= cur_tag;
    end
  end

endmodule

`default_nettype wire

// File: design/axil_req_slave.sv
`timescale 1ns/1ps
`default_nettype none

module axil_req_slave
  import brisc_pkg::*;
(
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic [AXI_ADDR_WIDTH-1:0] awaddr,
  input  logic                      awvalid,
  output logic                      awready,
  input  logic [WORD_WIDTH-1:0]     wdata,
  input  logic [STRB_WIDTH-1:0]     wstrb,
  input  logic                      wvalid,
  output logic                      wready,
  input  logic [AXI_ADDR_WIDTH-1:0] araddr,
  input  logic                      arvalid,
  output logic                      arready,
  output logic                      req_valid,
  output logic                      req_write,
  output addr_u                     req_addr,
  output logic [WORD_WIDTH-1:0]     req_wdata,
  output logic [STRB_WIDTH-1:0]     req_wstrb,
  input  logic                      req_ready,
  input  logic                      resp_done
);

  logic busy;      // One transaction in flight.
  logic aw_held;   // AW taken, W still missing.
  logic w_held;    // W taken, AW still missing.
  logic aw_take;
  logic w_take;
  logic ar_take;
  logic write_go;

  assign awready = ~busy & ~aw_held;
  assign wready  = ~busy & ~w_held;
  // Any write activity blocks the read channel.
  assign arready = ~busy & ~aw_held & ~w_held & ~awvalid & ~wvalid;

  assign aw_take  = awvalid & awready;
  assign w_take   = wvalid & wready;
  assign ar_take  = arvalid & arready;
  assign write_go = (aw_held | aw_take) & (w_held | w_take);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      busy      <= 1'b0;
      aw_held   <= 1'b0;
      w_held    <= 1'b0;
      req_valid <= 1'b0;
    end else begin
      aw_held <= (aw_held | aw_take) & ~write_go;
      w_held  <= (w_held | w_take) & ~write_go;
      if (write_go || ar_take) begin
        busy      <= 1'b1;
        req_valid <= 1'b1;
      end else begin
        if (req_valid && req_ready) begin
          req_valid <= 1'b0;  // Cache has it.
        end
        if (resp_done) begin
          busy <= 1'b0;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (aw_take) begin
      req_addr.raw <= awaddr[ADDRESS_WIDTH-1:0];
    end else if (ar_take) begin
      req_addr.raw <= araddr[ADDRESS_WIDTH-1:0];
    end
    if (w_take) begin
      req_wdata <= wdata;
      req_wstrb <= wstrb;
    end
    if (write_go) begin
      req_write <= 1'b1;
    end else if (ar_take) begin
      req_write <= 1'b0;
    end
  end

endmodule

`default_nettype wire

// File: design/brisc_pkg.sv
`default_nettype none

package brisc_pkg;

  //////////////////////////////
  // Data path widths.
  localparam int unsigned WORD_WIDTH       = 32;
  localparam int unsigned BYTE_WIDTH       = 8;
  localparam int unsigned STRB_WIDTH       = WORD_WIDTH / BYTE_WIDTH;
  localparam int unsigned AXI_ADDR_WIDTH   = 32;
  localparam int unsigned ADDRESS_WIDTH    = 10;  // Byte address actually decoded.
  localparam logic [1:0]  RESP_OKAY        = 2'b00;

  //////////////////////////////
  // Cache and memory geometry.
  localparam int unsigned CACHE_LINE_WIDTH = 128;
  localparam int unsigned WORDS_PER_LINE   = CACHE_LINE_WIDTH / WORD_WIDTH;
  localparam int unsigned CACHE_SETS       = 4;
  localparam int unsigned INDEX_WIDTH      = $clog2(CACHE_SETS);
  localparam int unsigned WORD_SEL_WIDTH   = $clog2(WORDS_PER_LINE);
  localparam int unsigned BYTE_SEL_WIDTH   = $clog2(STRB_WIDTH);
  localparam int unsigned TAG_WIDTH        =
      ADDRESS_WIDTH - INDEX_WIDTH - WORD_SEL_WIDTH - BYTE_SEL_WIDTH;
  localparam int unsigned LINE_ADDR_WIDTH  = TAG_WIDTH + INDEX_WIDTH;
  localparam int unsigned MEM_LINES        = 2 ** LINE_ADDR_WIDTH;
  localparam int unsigned MEM_RESP_DELAY   = 6;  // One way, in cycles.
  localparam int unsigned DELAY_CNT_WIDTH  = $clog2(MEM_RESP_DELAY + 1);

  // Cache FSM encoding.
  localparam logic [2:0] ST_IDLE      = 3'd0;
  localparam logic [2:0] ST_LOOKUP    = 3'd1;
  localparam logic [2:0] ST_EVICT     = 3'd2;
  localparam logic [2:0] ST_FILL_WAIT = 3'd3;
  localparam logic [2:0] ST_RESPOND   = 3'd4;

  typedef struct packed {
    logic [TAG_WIDTH-1:0]      tag;
    logic [INDEX_WIDTH-1:0]    index;
    logic [WORD_SEL_WIDTH-1:0] word;
    logic [BYTE_SEL_WIDTH-1:0] byte_off;
  } addr_fields_t;

  // Raw on the bus side, split into fields inside the cache.
  typedef union packed {
    logic [ADDRESS_WIDTH-1:0] raw;
    addr_fields_t             fields;
  } addr_u;

endpackage

`default_nettype wire
